//--- run.sh
#!/bin/sh
# Compile and run the writeback stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module wb_stage_tb -o wb_stage_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/wb_stage_tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error"
  cat sim.log
  exit 1
fi
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- src/csr_file.sv
`timescale 1ns/1ns

module csr_file
  import wb_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic [csr_addr_width-1:0] csr_s,
  input  logic [csr_addr_width-1:0] csr_d,
  input  logic                      csr_commit,
  input  logic [xlen-1:0]           csr_wdata,
  input  logic                      trap_take,
  input  logic [xlen-1:0]           trap_cause,
  input  logic [xlen-1:0]           trap_pc,
  output logic [xlen-1:0]           csr_src,
  output logic [xlen-1:0]           mtvec,
  output logic [xlen-1:0]           mepc
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mcause;

  // ####################################################################
  // Register updates.
  // ####################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= mstatus_reset;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (trap_take) begin
      mcause <= trap_cause;
      mepc   <= trap_pc;
    end else if (csr_commit) begin
      // mcause is read-only from software here.
      case (csr_d)
        csr_mstatus: mstatus <= csr_wdata;
        csr_mtvec:   mtvec   <= csr_wdata;
        csr_mepc:    mepc    <= csr_wdata;
        default: ;
      endcase
    end
  end

  // ####################################################################
  // Read multiplexer.
  // ####################################################################

  always_comb begin
    case (csr_s)
      csr_mstatus:   csr_src = mstatus;
      csr_mtvec:     csr_src = mtvec;
      csr_mepc:      csr_src = mepc;
      csr_mcause:    csr_src = mcause;
      csr_mvendorid: csr_src = mvendorid_value;
      csr_marchid:   csr_src = marchid_value;
      default:       csr_src = '0;
    endcase
  end

  // The redirect unit must never let a software write race a trap.
  a_trap_vs_write: assert property (
    @(posedge clock) disable iff (reset)
    !(trap_take && csr_commit)
  ) else $error("csr_file: trap and CSR write in the same cycle");

endmodule

//--- src/gpr_file.sv
`timescale 1ns/1ns

module gpr_file
  import wb_pkg::*;
#(
  parameter int NUM_REGS = 16
) (
  input  logic            clock,
  input  logic            reset,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            gpr_wen,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] src1,
  output logic [xlen-1:0] src2
);

  localparam int idx_width = $clog2(NUM_REGS);

  logic [xlen-1:0]      regs [NUM_REGS];
  logic [idx_width-1:0] rs1_idx;
  logic [idx_width-1:0] rs2_idx;
  logic [idx_width-1:0] rd_idx;

  // RV32E only decodes the low four bits of a register number.
  assign rs1_idx = rs1[idx_width-1:0];
  assign rs2_idx = rs2[idx_width-1:0];
  assign rd_idx  = rd[idx_width-1:0];

  // ####################################################################
  // Read ports, no bypass.
  // ####################################################################

  assign src1 = regs[rs1_idx];
  assign src2 = regs[rs2_idx];

  // ####################################################################
  // Write port.
  // ####################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (gpr_wen && rd_idx != '0) begin
      regs[rd_idx] <= wdata;
    end
  end

  // x0 stays zero whatever the commit logic lets through.
  a_zero_reg: assert property (
    @(posedge clock) disable iff (reset)
    gpr_wen |=> regs[0] == '0
  ) else $error("gpr_file: register zero was written");

endmodule

//--- src/trap_redirect.sv
`timescale 1ns/1ns

module trap_redirect
  import wb_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            ls_valid,
  input  logic            wen,
  input  logic            csr_wen,
  input  logic            inst_addr_misaligned,
  input  logic            ecall,
  input  logic            load_addr_misaligned,
  input  logic            store_addr_misaligned,
  input  logic            mret,
  input  logic            fence_i,
  input  logic            is_wrong_prediction,
  input  logic [xlen-1:0] lsu_pc,
  input  logic [xlen-1:0] exu_npc,
  input  logic [xlen-1:0] mtvec,
  input  logic [xlen-1:0] mepc,
  output logic            gpr_wen,
  output logic            csr_commit,
  output logic            trap_take,
  output logic [xlen-1:0] trap_cause,
  output logic [xlen-1:0] trap_pc,
  output logic [xlen-1:0] npc,
  output logic            npc_valid,
  output logic            clear_pipeline,
  output logic            clear_cache
);

  logic exception;
  logic commit;

  assign exception = inst_addr_misaligned | ecall | load_addr_misaligned |
                     store_addr_misaligned;

  // Everything arriving during a clear cycle belongs to a flushed path.
  assign commit = !clear_pipeline;

  assign gpr_wen    = wen && commit;
  assign csr_commit = csr_wen && commit && !exception;
  assign trap_take  = exception && commit;
  assign trap_pc    = lsu_pc;

  // ####################################################################
  // Cause selection, fixed priority.
  // ####################################################################

  always_comb begin
    if (inst_addr_misaligned) begin
      trap_cause = cause_inst_misaligned;
    end else if (ecall) begin
      trap_cause = cause_ecall;
    end else if (load_addr_misaligned) begin
      trap_cause = cause_load_misaligned;
    end else begin
      trap_cause = cause_store_misaligned;
    end
  end

  // ####################################################################
  // Redirect and clear pulses.
  // ####################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      npc            <= '0;
      npc_valid      <= 1'b0;
      clear_pipeline <= 1'b0;
      clear_cache    <= 1'b0;
    end else if (!commit) begin
      npc_valid      <= 1'b0;
      clear_pipeline <= 1'b0;
      clear_cache    <= 1'b0;
    end else begin
      npc_valid <= ls_valid;
      if (exception) begin
        npc            <= mtvec;
        clear_pipeline <= 1'b1;
        clear_cache    <= 1'b0;
      end else begin
        npc            <= mret ? mepc : exu_npc;
        clear_pipeline <= mret | fence_i | is_wrong_prediction;
        clear_cache    <= fence_i;
      end
    end
  end

  a_single_clear: assert property (
    @(posedge clock) disable iff (reset)
    clear_pipeline |=> !clear_pipeline
  ) else $error("trap_redirect: clear_pipeline held for two cycles");

endmodule

//--- src/wb_pkg.sv
package wb_pkg;

  // ####################################################################
  // Widths.
  // ####################################################################

  parameter int xlen = 32;
  parameter int csr_addr_width = 12;

  // ####################################################################
  // Machine CSR addresses.
  // ####################################################################

  parameter logic [csr_addr_width-1:0] csr_mstatus   = 12'h300;
  parameter logic [csr_addr_width-1:0] csr_mtvec     = 12'h305;
  parameter logic [csr_addr_width-1:0] csr_mepc      = 12'h341;
  parameter logic [csr_addr_width-1:0] csr_mcause    = 12'h342;
  parameter logic [csr_addr_width-1:0] csr_mvendorid = 12'hF11;
  parameter logic [csr_addr_width-1:0] csr_marchid   = 12'hF12;

  // ####################################################################
  // Exception cause codes, as written to mcause.
  // ####################################################################

  parameter logic [xlen-1:0] cause_inst_misaligned  = 32'd0;
  parameter logic [xlen-1:0] cause_ecall            = 32'd11;
  parameter logic [xlen-1:0] cause_load_misaligned  = 32'd4;
  parameter logic [xlen-1:0] cause_store_misaligned = 32'd6;

  // ####################################################################
  // Reset and identity values.
  // ####################################################################

  // MPP field set to machine mode.
  parameter logic [xlen-1:0] mstatus_reset   = 32'h0000_1800;
  parameter logic [xlen-1:0] mvendorid_value = 32'h7973_7978;
  parameter logic [xlen-1:0] marchid_value   = 32'h017D_9F58;

endpackage

//--- src/wb_stage.sv
`timescale 1ns/1ns

module wb_stage
  import wb_pkg::*;
#(
  parameter int NUM_REGS = 16
) (
  input  logic                      clock,
  input  logic                      reset,
  // Register and CSR reads.
  input  logic [4:0]                rs1,
  input  logic [4:0]                rs2,
  input  logic [csr_addr_width-1:0] csr_s,
  // Writeback.
  input  logic [4:0]                rd,
  input  logic                      wen,
  input  logic [xlen-1:0]           wdata,
  input  logic [csr_addr_width-1:0] csr_d,
  input  logic                      csr_wen,
  input  logic [xlen-1:0]           csr_wdata,
  // Status from the load/store stage.
  input  logic                      ls_valid,
  input  logic [xlen-1:0]           lsu_pc,
  input  logic [xlen-1:0]           exu_npc,
  // Events.
  input  logic                      inst_addr_misaligned,
  input  logic                      ecall,
  input  logic                      load_addr_misaligned,
  input  logic                      store_addr_misaligned,
  input  logic                      mret,
  input  logic                      fence_i,
  input  logic                      is_wrong_prediction,
  // Results and redirect.
  output logic [xlen-1:0]           src1,
  output logic [xlen-1:0]           src2,
  output logic [xlen-1:0]           csr_src,
  output logic [xlen-1:0]           npc,
  output logic                      npc_valid,
  output logic                      clear_pipeline,
  output logic                      clear_cache
);

  logic            gpr_wen;
  logic            csr_commit;
  logic            trap_take;
  logic [xlen-1:0] trap_cause;
  logic [xlen-1:0] trap_pc;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;

  gpr_file #(
    .NUM_REGS (NUM_REGS)
  ) u_gpr_file (
    .clock   (clock),
    .reset   (reset),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .gpr_wen (gpr_wen),
    .wdata   (wdata),
    .src1    (src1),
    .src2    (src2)
  );

  csr_file u_csr_file (
    .clock      (clock),
    .reset      (reset),
    .csr_s      (csr_s),
    .csr_d      (csr_d),
    .csr_commit (csr_commit),
    .csr_wdata  (csr_wdata),
    .trap_take  (trap_take),
    .trap_cause (trap_cause),
    .trap_pc    (trap_pc),
    .csr_src    (csr_src),
    .mtvec      (mtvec),
    .mepc       (mepc)
  );

  trap_redirect u_trap_redirect (
    .clock                 (clock),
    .reset                 (reset),
    .ls_valid              (ls_valid),
    .wen                   (wen),
    .csr_wen               (csr_wen),
    .inst_addr_misaligned  (inst_addr_misaligned),
    .ecall                 (ecall),
    .load_addr_misaligned  (load_addr_misaligned),
    .store_addr_misaligned (store_addr_misaligned),
    .mret                  (mret),
    .fence_i               (fence_i),
    .is_wrong_prediction   (is_wrong_prediction),
    .lsu_pc                (lsu_pc),
    .exu_npc               (exu_npc),
    .mtvec                 (mtvec),
    .mepc                  (mepc),
    .gpr_wen               (gpr_wen),
    .csr_commit            (csr_commit),
    .trap_take             (trap_take),
    .trap_cause            (trap_cause),
    .trap_pc               (trap_pc),
    .npc                   (npc),
    .npc_valid             (npc_valid),
    .clear_pipeline        (clear_pipeline),
    .clear_cache           (clear_cache)
  );

endmodule

//--- tb.f
+incdir+verif
src/wb_pkg.sv
src/gpr_file.sv
src/csr_file.sv
src/trap_redirect.sv
src/wb_stage.sv
verif/wb_stage_tb.sv

//--- verif/wb_vectors.svh
  task automatic fill_table();
    // Columns are rs1, rs2, csr_s, rd, wen, csr_d, csr_wen, wdata, ls_valid, pc, events,
    // then src1, src2, csr_src, npc and flags {npc_valid, clear_pipeline, clear_cache}.
    // Events are {inst, ecall, load, store, mret, fence_i, wrong prediction}.
    add_row("gpr_write_x1", row_t'{5'd0, 5'd0, csr_mstatus, 5'd1, 1'b1, csr_mtvec, 1'b1,
      32'h800, 1'b1, 32'h100, 7'b0000000, 32'h0, 32'h0, mstatus_reset, 32'h104, 3'b100});
    add_row("gpr_write_x0", row_t'{5'd1, 5'd1, csr_mtvec, 5'd0, 1'b1, csr_mepc, 1'b1,
      32'h200, 1'b0, 32'h104, 7'b0000000, 32'h800, 32'h800, 32'h800, 32'h108, 3'b000});
    add_row("csr_write_mstatus", row_t'{5'd0, 5'd1, csr_mepc, 5'd2, 1'b1, csr_mstatus, 1'b1,
      32'h88, 1'b1, 32'h108, 7'b0000000, 32'h0, 32'h800, 32'h200, 32'h10C, 3'b100});
    add_row("csr_write_mcause", row_t'{5'd2, 5'd2, csr_mstatus, 5'd0, 1'b0, csr_mcause, 1'b1,
      32'hFFFFFFFF, 1'b1, 32'h10C, 7'b0000000, 32'h88, 32'h88, 32'h88, 32'h110, 3'b100});
    add_row("csr_write_unknown", row_t'{5'd0, 5'd0, csr_mcause, 5'd0, 1'b0, 12'h7C0, 1'b1,
      32'h12345678, 1'b1, 32'h110, 7'b0000000, 32'h0, 32'h0, 32'h0, 32'h114, 3'b100});
    add_row("csr_read_unknown", row_t'{5'd0, 5'd0, 12'h7C0, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h114, 7'b0000000, 32'h0, 32'h0, 32'h0, 32'h118, 3'b100});
    add_row("exc_store", row_t'{5'd1, 5'd2, csr_mvendorid, 5'd3, 1'b1, csr_mtvec, 1'b1,
      32'h33, 1'b1, 32'h300, 7'b0001000, 32'h800, 32'h88, mvendorid_value, 32'h800, 3'b110});
    add_row("squash_after_store", row_t'{5'd3, 5'd3, csr_marchid, 5'd3, 1'b1, csr_mepc, 1'b1,
      32'hBAD00000, 1'b1, 32'h500, 7'b0100000, 32'h33, 32'h33, marchid_value, 32'h800, 3'b000});
    add_row("exc_load_store", row_t'{5'd3, 5'd3, csr_mepc, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h304, 7'b0011000, 32'h33, 32'h33, 32'h300, 32'h800, 3'b110});
    add_row("squash_after_load", row_t'{5'd0, 5'd0, csr_mcause, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h504, 7'b0000000, 32'h0, 32'h0, 32'h4, 32'h800, 3'b000});
    add_row("exc_ecall_load", row_t'{5'd0, 5'd0, csr_mtvec, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b0, 32'h308, 7'b0111000, 32'h0, 32'h0, 32'h800, 32'h800, 3'b010});
    add_row("squash_after_ecall", row_t'{5'd0, 5'd0, csr_mcause, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h508, 7'b0000000, 32'h0, 32'h0, 32'hB, 32'h800, 3'b000});
    add_row("exc_all_flags", row_t'{5'd0, 5'd0, csr_mepc, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h30C, 7'b1111000, 32'h0, 32'h0, 32'h308, 32'h800, 3'b110});
    add_row("squash_after_inst", row_t'{5'd0, 5'd0, csr_mcause, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h50C, 7'b0000000, 32'h0, 32'h0, 32'h0, 32'h800, 3'b000});
    add_row("mret", row_t'{5'd0, 5'd0, csr_mepc, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h600, 7'b0000100, 32'h0, 32'h0, 32'h30C, 32'h30C, 3'b110});
    add_row("squash_after_mret", row_t'{5'd0, 5'd0, csr_mstatus, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h604, 7'b0000000, 32'h0, 32'h0, 32'h88, 32'h30C, 3'b000});
    add_row("wrong_prediction", row_t'{5'd0, 5'd0, csr_mstatus, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h3FC, 7'b0000001, 32'h0, 32'h0, 32'h88, 32'h400, 3'b110});
    add_row("squash_after_mispredict", row_t'{5'd0, 5'd0, csr_mstatus, 5'd0, 1'b0, 12'h000,
      1'b0, 32'h0, 1'b1, 32'h700, 7'b0000000, 32'h0, 32'h0, 32'h88, 32'h400, 3'b000});
    add_row("fence_i", row_t'{5'd0, 5'd0, csr_mstatus, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h404, 7'b0000010, 32'h0, 32'h0, 32'h88, 32'h408, 3'b111});
    add_row("squash_after_fence", row_t'{5'd0, 5'd0, csr_mstatus, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h800, 7'b0000000, 32'h0, 32'h0, 32'h88, 32'h408, 3'b000});
    add_row("exc_ecall_only", row_t'{5'd0, 5'd0, csr_mepc, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h310, 7'b0100000, 32'h0, 32'h0, 32'h30C, 32'h800, 3'b110});
    add_row("squash_after_ecall_only", row_t'{5'd0, 5'd0, csr_mcause, 5'd0, 1'b0, 12'h000,
      1'b0, 32'h0, 1'b1, 32'h510, 7'b0000000, 32'h0, 32'h0, 32'hB, 32'h800, 3'b000});
    add_row("exc_load_only", row_t'{5'd0, 5'd0, csr_mepc, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h314, 7'b0010000, 32'h0, 32'h0, 32'h310, 32'h800, 3'b110});
    add_row("squash_after_load_only", row_t'{5'd0, 5'd0, csr_mcause, 5'd0, 1'b0, 12'h000,
      1'b0, 32'h0, 1'b1, 32'h514, 7'b0000000, 32'h0, 32'h0, 32'h4, 32'h800, 3'b000});
    add_row("exc_inst_only", row_t'{5'd0, 5'd0, csr_mepc, 5'd0, 1'b0, 12'h000, 1'b0,
      32'h0, 1'b1, 32'h318, 7'b1000000, 32'h0, 32'h0, 32'h314, 32'h800, 3'b110});
    add_row("squash_after_inst_only", row_t'{5'd0, 5'd0, csr_mcause, 5'd0, 1'b0, 12'h000,
      1'b0, 32'h0, 1'b1, 32'h518, 7'b0000000, 32'h0, 32'h0, 32'h0, 32'h800, 3'b000});
  endtask

//--- verif/wb_stage_tb.sv
`timescale 1ns/1ns

module wb_stage_tb
  import wb_pkg::*;
();

  // One table row. Stimulus first, expected outputs last.
  typedef struct packed {
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [csr_addr_width-1:0] csr_s;
    logic [4:0]                rd;
    logic                      wen;
    logic [csr_addr_width-1:0] csr_d;
    logic                      csr_wen;
    logic [xlen-1:0]           wdata;
    logic                      ls_valid;
    logic [xlen-1:0]           pc;
    logic [6:0]                events;
    logic [xlen-1:0]           e_src1;
    logic [xlen-1:0]           e_src2;
    logic [xlen-1:0]           e_csr_src;
    logic [xlen-1:0]           e_npc;
    logic [2:0]                e_flags;
  } row_t;

  logic                      clock = 1'b0;
  logic                      reset = 1'b1;
  logic [4:0]                rs1 = '0;
  logic [4:0]                rs2 = '0;
  logic [4:0]                rd = '0;
  logic [csr_addr_width-1:0] csr_s = '0;
  logic [csr_addr_width-1:0] csr_d = '0;
  logic                      wen = 1'b0;
  logic                      csr_wen = 1'b0;
  logic [xlen-1:0]           wdata = '0;
  logic [xlen-1:0]           csr_wdata = '0;
  logic                      ls_valid = 1'b0;
  logic [xlen-1:0]           lsu_pc = '0;
  logic [xlen-1:0]           exu_npc = '0;
  logic                      inst_addr_misaligned = 1'b0;
  logic                      ecall = 1'b0;
  logic                      load_addr_misaligned = 1'b0;
  logic                      store_addr_misaligned = 1'b0;
  logic                      mret = 1'b0;
  logic                      fence_i = 1'b0;
  logic                      is_wrong_prediction = 1'b0;
  logic [xlen-1:0]           src1;
  logic [xlen-1:0]           src2;
  logic [xlen-1:0]           csr_src;
  logic [xlen-1:0]           npc;
  logic                      npc_valid;
  logic                      clear_pipeline;
  logic                      clear_cache;

  row_t  rows [32];
  string names [32];
  int    num_rows = 0;
  int    errors = 0;
  int    checks = 0;
  int    waited = 0;

  always #5 clock = ~clock;

  wb_stage #(
    .NUM_REGS (16)
  ) uut (.*);

  initial begin
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
  end

  // ####################################################################
  // Table handling and checks.
  // ####################################################################

  task automatic add_row(input string name, input row_t row);
    names[num_rows] = name;
    rows[num_rows] = row;
    num_rows++;
  endtask

  task automatic apply_row(input row_t r);
    rs1       = r.rs1;
    rs2       = r.rs2;
    csr_s     = r.csr_s;
    rd        = r.rd;
    wen       = r.wen;
    wdata     = r.wdata;
    csr_d     = r.csr_d;
    csr_wen   = r.csr_wen;
    csr_wdata = r.wdata;
    ls_valid  = r.ls_valid;
    lsu_pc    = r.pc;
    exu_npc   = r.pc + 32'd4;
    {inst_addr_misaligned, ecall, load_addr_misaligned, store_addr_misaligned,
     mret, fence_i, is_wrong_prediction} = r.events;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: %s %s expected %h actual %h", test, what, expected, actual);
    end
  endtask

  `include "wb_vectors.svh"

  initial begin
    fill_table();
    // Outputs right after the first reset edge.
    @(posedge clock);
    #1;
    check_value("reset", "flags", '0, xlen'({npc_valid, clear_pipeline, clear_cache}));
    check_value("reset", "npc", '0, npc);
    while (reset && waited < 20) begin
      @(posedge clock);
      waited++;
    end
    if (reset) begin
      $display("Timeout: reset was still high after 20 clock cycles");
      $display("Result: FAILED");
      $finish;
    end else begin
      #1;
      for (int i = 0; i < num_rows; i++) begin
        apply_row(rows[i]);
        // Reads settle within the cycle.
        #7;
        check_value(names[i], "src1", rows[i].e_src1, src1);
        check_value(names[i], "src2", rows[i].e_src2, src2);
        check_value(names[i], "csr_src", rows[i].e_csr_src, csr_src);
        @(posedge clock);
        #1;
        check_value(names[i], "npc", rows[i].e_npc, npc);
        check_value(names[i], "flags", xlen'(rows[i].e_flags),
                    xlen'({npc_valid, clear_pipeline, clear_cache}));
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule
